// File: src/soc_pkg.sv
// SoC host-access package
// shared bus widths, reset hold length, host command types and AXI channel structs
package soc_pkg;

    localparam int unsigned ADDR_WIDTH      = 32;
    localparam int unsigned SOC_DATA_WIDTH  = 32;
    localparam int unsigned RST_HOLD_CYCLES = 4;
    localparam logic [1:0]  BURST_INCR      = 2'b01;

    typedef enum logic {
        HOST_READ  = 1'b0,
        HOST_WRITE = 1'b1
    } host_op_e;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

    // host side, always 64 bits wide; a 32-bit host uses the low half
    typedef struct packed {
        host_op_e               op;
        logic [ADDR_WIDTH-1:0]  addr;
        logic [63:0]            wdata;
        logic [7:0]             wstrb;
    } host_cmd_t;

    typedef struct packed {
        logic [63:0] rdata;
        axi_resp_e   resp;
    } host_rsp_t;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [7:0]            len;
        logic [2:0]            size;
        logic [1:0]            burst;
        logic                  valid;
    } axi_aw_t;

    typedef axi_aw_t axi_ar_t;

    typedef struct packed {
        logic [SOC_DATA_WIDTH-1:0]   data;
        logic [SOC_DATA_WIDTH/8-1:0] strb;
        logic                        last;
        logic                        valid;
    } axi_w_t;

    typedef struct packed {
        axi_resp_e resp;
        logic      valid;
    } axi_b_t;

    typedef struct packed {
        logic [SOC_DATA_WIDTH-1:0] data;
        axi_resp_e                 resp;
        logic                      last;
        logic                      valid;
    } axi_r_t;

    typedef struct packed {
        axi_aw_t aw;
        axi_w_t  w;
        axi_ar_t ar;
        logic    bready;
        logic    rready;
    } axi_req_t;

    typedef struct packed {
        axi_b_t b;
        axi_r_t r;
        logic   awready;
        logic   wready;
        logic   arready;
    } axi_rsp_t;

    // 64-bit flavour between the command master and the downsizer
    typedef struct packed {
        logic [63:0] data;
        logic [7:0]  strb;
        logic        last;
        logic        valid;
    } wide_w_t;

    typedef struct packed {
        logic [63:0] data;
        axi_resp_e   resp;
        logic        last;
        logic        valid;
    } wide_r_t;

    typedef struct packed {
        axi_aw_t aw;
        wide_w_t w;
        axi_ar_t ar;
        logic    bready;
        logic    rready;
    } wide_req_t;

    typedef struct packed {
        axi_b_t  b;
        wide_r_t r;
        logic    awready;
        logic    wready;
        logic    arready;
    } wide_rsp_t;

endpackage : soc_pkg

// File: src/host_cmd_master.sv
// Host command master
// turns a host command strobe into one single-beat AXI write or read
// and returns the B or R result as a response strobe
`timescale 1ns/1ps

module host_cmd_master #(
    parameter int unsigned DATA_WIDTH = 64,
    parameter type         req_t      = soc_pkg::wide_req_t,
    parameter type         rsp_t      = soc_pkg::wide_rsp_t
) (
    input  logic               sys_clock_i,
    input  logic               rst_n_i,
    input  logic               cmd_valid_i,
    input  soc_pkg::host_cmd_t cmd_i,
    output logic               rsp_valid_o,
    output soc_pkg::host_rsp_t rsp_o,
    output logic               busy_o,
    output req_t               axi_req_o,
    input  rsp_t               axi_rsp_i
);

    localparam int unsigned AW   = soc_pkg::ADDR_WIDTH;
    localparam int unsigned OFFS = $clog2(DATA_WIDTH / 8);  // byte offset bits

    typedef enum logic [2:0] {
        IDLE,
        WR_ADDR_DATA,
        WR_RESP,
        RD_ADDR,
        RD_DATA
    } state_e;

    state_e             state_q;
    logic               aw_done_q;
    logic               w_done_q;
    logic               rsp_valid_q;
    logic               aw_fire;
    logic               w_fire;
    soc_pkg::host_cmd_t cmd_q;
    soc_pkg::host_rsp_t rsp_q;
    soc_pkg::axi_aw_t   ax;

    assign aw_fire = axi_req_o.aw.valid && axi_rsp_i.awready;
    assign w_fire  = axi_req_o.w.valid && axi_rsp_i.wready;

    always_ff @(posedge sys_clock_i) begin
        if (!rst_n_i) begin
            state_q     <= IDLE;
            aw_done_q   <= 1'b0;
            w_done_q    <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (cmd_valid_i) begin
                        aw_done_q <= 1'b0;
                        w_done_q  <= 1'b0;
                        if (cmd_i.op == soc_pkg::HOST_WRITE) begin
                            state_q <= WR_ADDR_DATA;
                        end else begin
                            state_q <= RD_ADDR;
                        end
                    end
                end
                WR_ADDR_DATA: begin
                    // AW and W may complete in different cycles
                    aw_done_q <= aw_done_q || aw_fire;
                    w_done_q  <= w_done_q || w_fire;
                    if ((aw_done_q || aw_fire) && (w_done_q || w_fire)) begin
                        state_q <= WR_RESP;
                    end
                end
                WR_RESP: begin
                    if (axi_rsp_i.b.valid) begin
                        state_q     <= IDLE;
                        rsp_valid_q <= 1'b1;
                    end
                end
                RD_ADDR: begin
                    if (axi_rsp_i.arready) state_q <= RD_DATA;
                end
                RD_DATA: begin
                    if (axi_rsp_i.r.valid) begin
                        state_q     <= IDLE;
                        rsp_valid_q <= 1'b1;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (state_q == IDLE && cmd_valid_i) begin
            cmd_q      <= cmd_i;
            cmd_q.addr <= {cmd_i.addr[AW-1:OFFS], {OFFS{1'b0}}};  // bus aligned
        end
        if (state_q == WR_RESP && axi_rsp_i.b.valid) begin
            rsp_q.rdata <= '0;
            rsp_q.resp  <= axi_rsp_i.b.resp;
        end
        if (state_q == RD_DATA && axi_rsp_i.r.valid) begin
            rsp_q.rdata <= 64'(axi_rsp_i.r.data);
            rsp_q.resp  <= axi_rsp_i.r.resp;
        end
    end

    // single beat, full bus width
    assign ax = '{addr: cmd_q.addr, len: 8'd0, size: 3'(OFFS),
                  burst: soc_pkg::BURST_INCR, valid: 1'b0};

    always_comb begin
        axi_req_o.aw       = ax;
        axi_req_o.aw.valid = (state_q == WR_ADDR_DATA) && !aw_done_q;
        axi_req_o.w.data   = cmd_q.wdata[DATA_WIDTH-1:0];
        axi_req_o.w.strb   = cmd_q.wstrb[DATA_WIDTH/8-1:0];
        axi_req_o.w.last   = 1'b1;
        axi_req_o.w.valid  = (state_q == WR_ADDR_DATA) && !w_done_q;
        axi_req_o.ar       = ax;
        axi_req_o.ar.valid = (state_q == RD_ADDR);
        axi_req_o.bready   = (state_q == WR_RESP);
        axi_req_o.rready   = (state_q == RD_DATA);
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o       = rsp_q;
    assign busy_o      = (state_q != IDLE) || rsp_valid_q;  // drops the cycle after rsp

    // host must wait for busy_o low before the next strobe
    a_no_cmd_while_busy: assert property (@(posedge sys_clock_i) disable iff (!rst_n_i)
        cmd_valid_i |-> !busy_o);

endmodule : host_cmd_master

// File: src/axi_dwidth_downsizer.sv
// AXI 64-to-32 downsizer
// a single 64-bit beat becomes a two-beat 32-bit INCR burst
// read beats are merged back into one 64-bit beat
`timescale 1ns/1ps

module axi_dwidth_downsizer (
    input  logic               sys_clock_i,
    input  logic               rst_n_i,
    input  soc_pkg::wide_req_t s_req_i,
    output soc_pkg::wide_rsp_t s_rsp_o,
    output soc_pkg::axi_req_t  m_req_o,
    input  soc_pkg::axi_rsp_t  m_rsp_i
);

    localparam int unsigned NW = soc_pkg::SOC_DATA_WIDTH;

    typedef enum logic {
        LOW_HALF,
        HIGH_HALF
    } phase_e;

    phase_e             w_phase_q;
    phase_e             r_phase_q;
    logic [NW-1:0]      rdata_lo_q;
    soc_pkg::axi_resp_e rresp_lo_q;
    logic               w_fire;
    logic               r_fire;

    assign w_fire = m_req_o.w.valid && m_rsp_i.wready;
    assign r_fire = m_rsp_i.r.valid && m_req_o.rready;

    always_comb begin
        m_req_o.aw      = s_req_i.aw;
        m_req_o.aw.len  = 8'd1;   // two beats
        m_req_o.aw.size = 3'd2;   // 4 bytes each
        m_req_o.ar      = s_req_i.ar;
        m_req_o.ar.len  = 8'd1;
        m_req_o.ar.size = 3'd2;

        if (w_phase_q == LOW_HALF) begin
            m_req_o.w.data = s_req_i.w.data[NW-1:0];
            m_req_o.w.strb = s_req_i.w.strb[NW/8-1:0];
        end else begin
            m_req_o.w.data = s_req_i.w.data[2*NW-1:NW];
            m_req_o.w.strb = s_req_i.w.strb[2*NW/8-1:NW/8];
        end
        m_req_o.w.last  = (w_phase_q == HIGH_HALF);
        m_req_o.w.valid = s_req_i.w.valid;
        m_req_o.bready  = s_req_i.bready;
        m_req_o.rready  = s_req_i.rready;

        s_rsp_o.awready = m_rsp_i.awready;
        s_rsp_o.arready = m_rsp_i.arready;
        s_rsp_o.wready  = m_rsp_i.wready && (w_phase_q == HIGH_HALF);  // wide beat done
        s_rsp_o.b       = m_rsp_i.b;

        s_rsp_o.r.data  = {m_rsp_i.r.data, rdata_lo_q};
        if (rresp_lo_q == soc_pkg::SLVERR || m_rsp_i.r.resp == soc_pkg::SLVERR) begin
            s_rsp_o.r.resp = soc_pkg::SLVERR;
        end else begin
            s_rsp_o.r.resp = soc_pkg::OKAY;
        end
        s_rsp_o.r.last  = m_rsp_i.r.last;
        s_rsp_o.r.valid = m_rsp_i.r.valid && (r_phase_q == HIGH_HALF);
    end

    always_ff @(posedge sys_clock_i) begin
        if (!rst_n_i) begin
            w_phase_q <= LOW_HALF;
            r_phase_q <= LOW_HALF;
        end else begin
            if (w_fire) begin
                w_phase_q <= (w_phase_q == LOW_HALF) ? HIGH_HALF : LOW_HALF;
            end
            if (r_fire) begin
                r_phase_q <= (r_phase_q == LOW_HALF) ? HIGH_HALF : LOW_HALF;
            end
        end
    end

    // hold the low read beat until the high one shows up
    always_ff @(posedge sys_clock_i) begin
        if (r_fire && r_phase_q == LOW_HALF) begin
            rdata_lo_q <= m_rsp_i.r.data;
            rresp_lo_q <= m_rsp_i.r.resp;
        end
    end

    // only single-beat wide transfers are split
    a_wide_aw_single: assert property (@(posedge sys_clock_i) disable iff (!rst_n_i)
        s_req_i.aw.valid |-> s_req_i.aw.len == 8'd0);
    a_wide_ar_single: assert property (@(posedge sys_clock_i) disable iff (!rst_n_i)
        s_req_i.ar.valid |-> s_req_i.ar.len == 8'd0);

endmodule : axi_dwidth_downsizer

// File: src/sys_master.sv
// System master
// holds the SoC in reset for a fixed count after rst_n_i releases,
// then builds the host master path for a 64-bit or 32-bit host
`timescale 1ns/1ps

module sys_master #(
    parameter int unsigned HOST_DATA_WIDTH = 64
) (
    input  logic               sys_clock_i,
    input  logic               rst_n_i,
    input  logic               cmd_valid_i,
    input  soc_pkg::host_cmd_t cmd_i,
    output logic               rsp_valid_o,
    output soc_pkg::host_rsp_t rsp_o,
    output logic               busy_o,
    output logic               sys_resetn_o,
    output soc_pkg::axi_req_t  m_axi_req_o,
    input  soc_pkg::axi_rsp_t  m_axi_rsp_i
);

    localparam int unsigned HOLD  = soc_pkg::RST_HOLD_CYCLES;
    localparam int unsigned CNT_W = $clog2(HOLD + 1);

    logic [CNT_W-1:0] hold_cnt_q;

    always_ff @(posedge sys_clock_i) begin
        if (!rst_n_i) begin
            hold_cnt_q   <= '0;
            sys_resetn_o <= 1'b0;
        end else if (!sys_resetn_o) begin
            hold_cnt_q   <= hold_cnt_q + 1'b1;
            sys_resetn_o <= (hold_cnt_q == CNT_W'(HOLD - 1));  // high after HOLD cycles
        end
    end

    if (HOST_DATA_WIDTH == 64) begin : g_wide_host
        soc_pkg::wide_req_t wide_req;
        soc_pkg::wide_rsp_t wide_rsp;

        host_cmd_master #(
            .DATA_WIDTH ( HOST_DATA_WIDTH     ),
            .req_t      ( soc_pkg::wide_req_t ),
            .rsp_t      ( soc_pkg::wide_rsp_t )
        ) u_cmd_master (
            .sys_clock_i ( sys_clock_i  ),
            .rst_n_i     ( sys_resetn_o ),
            .cmd_valid_i ( cmd_valid_i  ),
            .cmd_i       ( cmd_i        ),
            .rsp_valid_o ( rsp_valid_o  ),
            .rsp_o       ( rsp_o        ),
            .busy_o      ( busy_o       ),
            .axi_req_o   ( wide_req     ),
            .axi_rsp_i   ( wide_rsp     )
        );

        axi_dwidth_downsizer u_downsizer (
            .sys_clock_i ( sys_clock_i  ),
            .rst_n_i     ( sys_resetn_o ),
            .s_req_i     ( wide_req     ),
            .s_rsp_o     ( wide_rsp     ),
            .m_req_o     ( m_axi_req_o  ),
            .m_rsp_i     ( m_axi_rsp_i  )
        );
    end else if (HOST_DATA_WIDTH == 32) begin : g_narrow_host
        // JTAG-style host, straight onto the SoC bus
        host_cmd_master #(
            .DATA_WIDTH ( HOST_DATA_WIDTH    ),
            .req_t      ( soc_pkg::axi_req_t ),
            .rsp_t      ( soc_pkg::axi_rsp_t )
        ) u_cmd_master (
            .sys_clock_i ( sys_clock_i  ),
            .rst_n_i     ( sys_resetn_o ),
            .cmd_valid_i ( cmd_valid_i  ),
            .cmd_i       ( cmd_i        ),
            .rsp_valid_o ( rsp_valid_o  ),
            .rsp_o       ( rsp_o        ),
            .busy_o      ( busy_o       ),
            .axi_req_o   ( m_axi_req_o  ),
            .axi_rsp_i   ( m_axi_rsp_i  )
        );
    end else begin : g_bad_width
        $error("sys_master: HOST_DATA_WIDTH must be 32 or 64");
    end

endmodule : sys_master

// File: src/axi_sram_slave.sv
// AXI SRAM slave
// 32-bit word memory with byte strobes and INCR bursts;
// accesses past the end of memory answer SLVERR
`timescale 1ns/1ps

module axi_sram_slave #(
    parameter int unsigned MEM_WORDS = 256
) (
    input  logic              sys_clock_i,
    input  logic              rst_n_i,
    input  soc_pkg::axi_req_t s_axi_req_i,
    output soc_pkg::axi_rsp_t s_axi_rsp_o
);

    localparam int unsigned      AW         = soc_pkg::ADDR_WIDTH;
    localparam int unsigned      DW         = soc_pkg::SOC_DATA_WIDTH;
    localparam int unsigned      IDX_W      = $clog2(MEM_WORDS);
    localparam logic [AW-1:0]    MEM_BYTES  = AW'(MEM_WORDS * 4);
    localparam logic [AW-1:0]    BEAT_BYTES = 4;

    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        WRITE_RESP,
        READ
    } state_e;

    state_e        state_q;
    logic [DW-1:0] mem [MEM_WORDS];
    logic [AW-1:0] addr_q;
    logic [AW-1:0] wr_addr;
    logic [7:0]    len_q;
    logic [7:0]    beat_q;
    logic [7:0]    wr_len;
    logic [7:0]    wr_beat;
    logic          err_q;
    logic          wr_err;
    logic          wr_last;
    logic          w_fire;
    logic          ar_fire;
    logic          r_fire;
    logic          wr_ok;
    logic          rd_ok;

    // first W beat may ride along with AW in IDLE
    assign wr_addr = (state_q == IDLE) ? s_axi_req_i.aw.addr : addr_q;
    assign wr_len  = (state_q == IDLE) ? s_axi_req_i.aw.len : len_q;
    assign wr_beat = (state_q == IDLE) ? 8'd0 : beat_q;
    assign wr_err  = (state_q == IDLE) ? 1'b0 : err_q;
    assign wr_last = (wr_beat == wr_len);
    assign wr_ok   = (wr_addr < MEM_BYTES);
    assign rd_ok   = (addr_q < MEM_BYTES);

    assign w_fire  = s_axi_req_i.w.valid && s_axi_rsp_o.wready;
    assign ar_fire = s_axi_req_i.ar.valid && s_axi_rsp_o.arready;
    assign r_fire  = s_axi_rsp_o.r.valid && s_axi_req_i.rready;

    always_ff @(posedge sys_clock_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (s_axi_req_i.aw.valid) begin
                        state_q <= (w_fire && wr_last) ? WRITE_RESP : WRITE;
                    end else if (ar_fire) begin
                        state_q <= READ;
                    end
                end
                WRITE:      if (w_fire && wr_last) state_q <= WRITE_RESP;
                WRITE_RESP: if (s_axi_req_i.bready) state_q <= IDLE;
                READ:       if (r_fire && beat_q == len_q) state_q <= IDLE;
                default:    state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (state_q == IDLE && s_axi_req_i.aw.valid) begin
            addr_q <= s_axi_req_i.aw.addr;
            len_q  <= s_axi_req_i.aw.len;
            beat_q <= 8'd0;
            err_q  <= 1'b0;
        end else if (ar_fire) begin
            addr_q <= s_axi_req_i.ar.addr;
            len_q  <= s_axi_req_i.ar.len;
            beat_q <= 8'd0;
        end
        if (w_fire) begin
            addr_q <= wr_addr + BEAT_BYTES;
            beat_q <= wr_beat + 8'd1;
            err_q  <= wr_err || !wr_ok;  // sticky over the burst
        end
        if (r_fire) begin
            addr_q <= addr_q + BEAT_BYTES;
            beat_q <= beat_q + 8'd1;
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (w_fire && wr_ok) begin
            for (int i = 0; i < DW / 8; i++) begin
                if (s_axi_req_i.w.strb[i]) begin
                    mem[wr_addr[IDX_W+1:2]][8*i +: 8] <= s_axi_req_i.w.data[8*i +: 8];
                end
            end
        end
    end

    always_comb begin
        s_axi_rsp_o.awready = (state_q == IDLE);
        s_axi_rsp_o.wready  = (state_q == IDLE && s_axi_req_i.aw.valid) || (state_q == WRITE);
        s_axi_rsp_o.arready = (state_q == IDLE) && !s_axi_req_i.aw.valid;  // writes first
        s_axi_rsp_o.b.valid = (state_q == WRITE_RESP);
        s_axi_rsp_o.b.resp  = err_q ? soc_pkg::SLVERR : soc_pkg::OKAY;
        s_axi_rsp_o.r.valid = (state_q == READ);
        s_axi_rsp_o.r.data  = rd_ok ? mem[addr_q[IDX_W+1:2]] : '0;
        s_axi_rsp_o.r.resp  = rd_ok ? soc_pkg::OKAY : soc_pkg::SLVERR;
        s_axi_rsp_o.r.last  = (beat_q == len_q);
    end

    // master's wlast has to agree with the AW burst length
    a_wlast_matches_len: assert property (@(posedge sys_clock_i) disable iff (!rst_n_i)
        w_fire |-> (s_axi_req_i.w.last == wr_last));

endmodule : axi_sram_slave

// File: src/soc_top.sv
// SoC host-access top
// host command master path feeding a stand-in memory slave
`timescale 1ns/1ps

module soc_top #(
    parameter int unsigned HOST_DATA_WIDTH = 64,
    parameter int unsigned MEM_WORDS       = 256
) (
    input  logic               sys_clock_i,
    input  logic               rst_n_i,
    input  logic               cmd_valid_i,
    input  soc_pkg::host_cmd_t cmd_i,
    output logic               rsp_valid_o,
    output soc_pkg::host_rsp_t rsp_o,
    output logic               busy_o,
    output logic               sys_resetn_o
);

    soc_pkg::axi_req_t soc_axi_req;  // 32-bit SoC bus
    soc_pkg::axi_rsp_t soc_axi_rsp;

    sys_master #(
        .HOST_DATA_WIDTH ( HOST_DATA_WIDTH )
    ) u_sys_master (
        .sys_clock_i  ( sys_clock_i  ),
        .rst_n_i      ( rst_n_i      ),
        .cmd_valid_i  ( cmd_valid_i  ),
        .cmd_i        ( cmd_i        ),
        .rsp_valid_o  ( rsp_valid_o  ),
        .rsp_o        ( rsp_o        ),
        .busy_o       ( busy_o       ),
        .sys_resetn_o ( sys_resetn_o ),
        .m_axi_req_o  ( soc_axi_req  ),
        .m_axi_rsp_i  ( soc_axi_rsp  )
    );

    axi_sram_slave #(
        .MEM_WORDS ( MEM_WORDS )
    ) u_sram (
        .sys_clock_i ( sys_clock_i  ),
        .rst_n_i     ( sys_resetn_o ),
        .s_axi_req_i ( soc_axi_req  ),
        .s_axi_rsp_o ( soc_axi_rsp  )
    );

endmodule : soc_top

// File: sim/tb_soc_top.sv
// Testbench for the SoC host-access top
// random write/read traffic, partial strobes and out-of-range accesses,
// checked against a byte-wide reference memory by concurrent assertions
`timescale 1ns/1ps

module tb_soc_top #(
    parameter int unsigned HOST_DATA_WIDTH = 64
);

    localparam int unsigned MEM_WORDS      = 256;
    localparam int unsigned MEM_BYTES      = MEM_WORDS * 4;
    localparam int unsigned BIDX_W         = $clog2(MEM_BYTES);
    localparam int unsigned BYTES          = HOST_DATA_WIDTH / 8;  // bytes per host beat
    localparam int unsigned SEED           = 32'h1da3_5a3d;
    localparam int unsigned N_RANDOM       = 60;
    localparam int unsigned N_PARTIAL      = 8;
    localparam int unsigned N_OOR          = 6;
    localparam int unsigned N_CMDS         = 2 * N_RANDOM + 2 * N_PARTIAL + 3 * N_OOR;
    localparam int unsigned TIMEOUT_CYCLES = 50 * N_CMDS + 100;
    localparam logic [7:0]  STRB_PAT [N_PARTIAL] = '{8'h01, 8'h0F, 8'hF0, 8'h81,
                                                    8'h5A, 8'h3C, 8'hC3, 8'h42};

    logic               sys_clock;
    logic               rst_n_i;
    logic               cmd_valid_i;
    soc_pkg::host_cmd_t cmd_i;
    logic               rsp_valid_o;
    soc_pkg::host_rsp_t rsp_o;
    logic               busy_o;
    logic               sys_resetn_o;

    logic [7:0]         ref_mem [MEM_BYTES];  // byte-wide model of the SRAM
    logic [31:0]        wr_addrs [$];
    logic [63:0]        exp_rdata;
    soc_pkg::axi_resp_e exp_resp;
    logic               chk_data;             // only reads carry data
    int                 pending;
    int                 cycles;
    int                 errors;
    int                 n_cmds;
    int                 n_rsps;

    soc_top #(
        .HOST_DATA_WIDTH ( HOST_DATA_WIDTH ),
        .MEM_WORDS       ( MEM_WORDS       )
    ) u_dut (
        .sys_clock_i  ( sys_clock    ),
        .rst_n_i      ( rst_n_i      ),
        .cmd_valid_i  ( cmd_valid_i  ),
        .cmd_i        ( cmd_i        ),
        .rsp_valid_o  ( rsp_valid_o  ),
        .rsp_o        ( rsp_o        ),
        .busy_o       ( busy_o       ),
        .sys_resetn_o ( sys_resetn_o )
    );

    initial begin
        sys_clock = 1'b0;
        forever #10 sys_clock = ~sys_clock;
    end

    // commands counted against response strobes
    always @(posedge sys_clock) begin
        cycles <= cycles + 1;
        if (cmd_valid_i && !rsp_valid_o) begin
            pending <= pending + 1;
        end else if (!cmd_valid_i && rsp_valid_o) begin
            pending <= pending - 1;
        end
        if (rsp_valid_o) n_rsps <= n_rsps + 1;
    end

    function automatic logic [31:0] rand_addr();
        return 32'(($urandom() % (MEM_BYTES / BYTES)) * BYTES);  // aligned and in range
    endfunction

    function automatic soc_pkg::axi_resp_e ref_resp(input logic [31:0] addr);
        return (addr < MEM_BYTES) ? soc_pkg::OKAY : soc_pkg::SLVERR;
    endfunction

    function automatic logic [63:0] ref_read(input logic [31:0] addr);
        logic [63:0]       data;
        logic [BIDX_W-1:0] idx;
        data = '0;  // out of range reads back zero
        if (addr < MEM_BYTES) begin
            for (int b = 0; b < BYTES; b++) begin
                idx = BIDX_W'(addr + 32'(b));
                data[8*b +: 8] = ref_mem[idx];
            end
        end
        return data;
    endfunction

    task automatic ref_write(input logic [31:0] addr, input logic [63:0] wdata,
                             input logic [7:0] wstrb);
        logic [BIDX_W-1:0] idx;
        if (addr < MEM_BYTES) begin
            for (int b = 0; b < BYTES; b++) begin
                if (wstrb[b]) begin
                    idx = BIDX_W'(addr + 32'(b));
                    ref_mem[idx] = wdata[8*b +: 8];
                end
            end
        end
    endtask

    // one strobe and a wait for its response
    task automatic run_command(input soc_pkg::host_op_e op, input logic [31:0] addr,
                               input logic [63:0] wdata, input logic [7:0] wstrb);
        while (busy_o) @(negedge sys_clock);
        exp_resp  = ref_resp(addr);
        exp_rdata = ref_read(addr);
        chk_data  = (op == soc_pkg::HOST_READ);
        if (op == soc_pkg::HOST_WRITE) ref_write(addr, wdata, wstrb);
        cmd_i.op    = op;
        cmd_i.addr  = addr;
        cmd_i.wdata = wdata;
        cmd_i.wstrb = wstrb;
        cmd_valid_i = 1'b1;
        n_cmds++;
        @(negedge sys_clock);
        cmd_valid_i = 1'b0;
        while (pending != 0) @(negedge sys_clock);
    endtask

    a_reset_quiet: assert property (@(posedge sys_clock)
        (cycles > 2 && !sys_resetn_o) |-> (!rsp_valid_o && !busy_o))
        else begin
            errors++;
            $display("%0t: rsp_valid_o or busy_o active while the SoC is in reset", $time);
        end

    a_resetn_timing: assert property (@(posedge sys_clock)
        $rose(rst_n_i) |-> ##(soc_pkg::RST_HOLD_CYCLES) $rose(sys_resetn_o))
        else begin
            errors++;
            $display("%0t: sys_resetn_o did not rise %0d cycles after rst_n_i",
                     $time, soc_pkg::RST_HOLD_CYCLES);
        end

    a_rsp_resp: assert property (@(posedge sys_clock) disable iff (!sys_resetn_o)
        rsp_valid_o |-> rsp_o.resp == exp_resp)
        else begin
            errors++;
            $display("FAIL %0t rsp_o.resp got %0d expected %0d", $time, rsp_o.resp, exp_resp);
        end

    a_rsp_rdata: assert property (@(posedge sys_clock) disable iff (!sys_resetn_o)
        (rsp_valid_o && chk_data) |-> rsp_o.rdata == exp_rdata)
        else begin
            errors++;
            $display("FAIL %0t rsp_o.rdata got %h expected %h", $time, rsp_o.rdata, exp_rdata);
        end

    a_one_rsp_per_cmd: assert property (@(posedge sys_clock) disable iff (!sys_resetn_o)
        rsp_valid_o |-> pending == 1)
        else begin
            errors++;
            $display("%0t: response strobe with %0d commands pending", $time, pending);
        end

    a_busy_falls: assert property (@(posedge sys_clock) disable iff (!sys_resetn_o)
        rsp_valid_o |=> !busy_o)
        else begin
            errors++;
            $display("%0t: busy_o still high the cycle after the response", $time);
        end

    // busy from the cycle after the strobe through the response cycle
    a_busy_tracks_cmd: assert property (@(posedge sys_clock) disable iff (!sys_resetn_o)
        busy_o == (pending != 0))
        else begin
            errors++;
            $display("FAIL %0t busy_o got %b expected %b",
                     $time, $sampled(busy_o), $sampled(pending != 0));
        end

    initial begin
        while (cycles < TIMEOUT_CYCLES) @(posedge sys_clock);
        $display("timeout after %0d cycles, the DUT stopped answering", cycles);
        $display("summary: %0d commands, %0d responses, %0d errors", n_cmds, n_rsps, errors);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        logic [31:0] addr;
        logic [31:0] oor_addr;
        logic [63:0] data;
        rst_n_i     = 1'b0;
        cmd_valid_i = 1'b0;
        cmd_i       = '0;
        exp_rdata   = '0;
        exp_resp    = soc_pkg::OKAY;
        chk_data    = 1'b0;
        pending     = 0;
        cycles      = 0;
        errors      = 0;
        n_cmds      = 0;
        n_rsps      = 0;
        void'($urandom(SEED));

        repeat (10) @(negedge sys_clock);
        rst_n_i = 1'b1;
        while (!sys_resetn_o) @(negedge sys_clock);
        @(negedge sys_clock);

        // full-strobe writes each read back
        for (int i = 0; i < N_RANDOM; i++) begin
            addr = rand_addr();
            data = {$urandom(), $urandom()};
            wr_addrs.push_back(addr);
            run_command(soc_pkg::HOST_WRITE, addr, data, 8'hFF);
            run_command(soc_pkg::HOST_READ, addr, 64'h0, 8'h00);
        end

        // partial strobes over words that already hold known data
        for (int i = 0; i < N_PARTIAL; i++) begin
            addr = wr_addrs[i];
            data = {$urandom(), $urandom()};
            run_command(soc_pkg::HOST_WRITE, addr, data, STRB_PAT[i]);
            run_command(soc_pkg::HOST_READ, addr, 64'h0, 8'h00);
        end

        // out-of-range accesses and a read of the untouched in-range alias
        for (int i = 0; i < N_OOR; i++) begin
            addr     = wr_addrs[N_PARTIAL + i];
            oor_addr = (i % 2 == 0) ? addr + 32'(MEM_BYTES) : addr + 32'hF000_0000;
            data     = {$urandom(), $urandom()};
            run_command(soc_pkg::HOST_WRITE, oor_addr, data, 8'hFF);
            run_command(soc_pkg::HOST_READ, oor_addr, 64'h0, 8'h00);
            run_command(soc_pkg::HOST_READ, addr, 64'h0, 8'h00);
        end

        repeat (5) @(negedge sys_clock);  // let the last checks settle
        $display("summary: %0d commands, %0d responses, %0d errors", n_cmds, n_rsps, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : tb_soc_top

// File: compile.f
src/soc_pkg.sv
src/host_cmd_master.sv
src/axi_dwidth_downsizer.sv
src/sys_master.sv
src/axi_sram_slave.sv
src/soc_top.sv
sim/tb_soc_top.sv

// File: Makefile
# Verilator build and run for the SoC host-access testbench
# override on the command line, e.g. make test HOST_DATA_WIDTH=32

VERILATOR       ?= verilator
HOST_DATA_WIDTH ?= 64
TOP             ?= tb_soc_top
BUILD_DIR       ?= obj_dir
LOG             ?= sim.log
VFLAGS          ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench (HOST_DATA_WIDTH=$(HOST_DATA_WIDTH))"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) -f compile.f --top-module $(TOP) \
		-GHOST_DATA_WIDTH=$(HOST_DATA_WIDTH) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "TEST OK" $(LOG); then echo "simulation passed"; \
	else echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
